// File: Makefile
# Verilator flow for the Z-core testbench

TOP = tb_z_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; \
	then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+.
z_core_pkg.sv
z_fetch_unit.sv
z_fetch_buffer.sv
z_exec_unit.sv
z_core_top.sv
tb_clock_gen.sv
tb_z_core.sv

// File: tb_clock_gen.sv
/*
 * Testbench clock
 * Free-running clock, period 100 time units
 */

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // Starts low, toggles every half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: tb_z_core.sv
/*
 * Z-core testbench
 * Directed programs run through the core and checked against a
 * reference model, with a random-latency instruction memory
 */

module tb_z_core;

    localparam int MEM_WORDS   = 64;
    localparam int ADDR_W      = 6;
    localparam int CYCLE_LIMIT = 3000;

    localparam logic [31:0] ecall_instr  = 32'h0000_0073;
    localparam logic [31:0] ebreak_instr = 32'h0010_0073;

    logic                  clk;
    logic                  rstn = 1'b0;
    logic                  imem_req;
    z_core_pkg::word_t     imem_addr;
    logic                  imem_ready = 1'b0;
    z_core_pkg::word_t     imem_rdata = '0;
    logic                  retire_valid;
    z_core_pkg::word_t     retire_pc;
    z_core_pkg::reg_addr_t retire_rd;
    logic                  retire_we;
    z_core_pkg::word_t     retire_value;
    logic                  halt;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] fetch_pc = '0;
    logic        busy = 1'b0;
    int          wait_left = 0;
    int          lat;
    int          load_idx = 0;
    int          errors = 0;
    int          addr_errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD(100)) u_clk (.clk(clk));

    z_core_top dut (
        .clk(clk), .rstn(rstn),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value), .halt(halt)
    );

    // ################################################
    // Instruction memory model
    // ################################################

    // Ready 1 to 4 cycles after req is seen, one-cycle pulse
    always @(posedge clk) begin
        if (!rstn) begin
            imem_ready <= 1'b0;
            busy       <= 1'b0;
            fetch_pc   <= 32'h0;
        end else if (imem_ready) begin
            imem_ready <= 1'b0;
        end else if (imem_req) begin
            if (!busy) begin
                lat = $urandom_range(3, 0);
            end
            if ((!busy && lat == 0) || (busy && wait_left == 0)) begin
                busy       <= 1'b0;
                imem_ready <= 1'b1;
                imem_rdata <= imem[imem_addr[7:2]];
                // Fetch must walk the program in order
                assert (imem_addr == fetch_pc) else begin
                    $display("MISMATCH @%0t: fetch address got %h expected %h",
                             $time, imem_addr, fetch_pc);
                    addr_errors <= addr_errors + 1;
                end
                fetch_pc <= fetch_pc + 32'd4;
            end else if (!busy) begin
                busy      <= 1'b1;
                wait_left <= lat - 1;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // Run limit, well above the longest program set
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ################################################
    // Reporting and encoders
    // ################################################

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] enc_lui(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    // Fill with custom-0 words, index kept in the upper bits
    task automatic clear_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[ADDR_W'(i)] = {i[24:0], 7'h0b};
        end
        load_idx = 0;
    endtask

    task automatic emit(input logic [31:0] instr);
        imem[ADDR_W'(load_idx)] = instr;
        load_idx++;
    endtask

    // ################################################
    // Reference model
    // ################################################

    // RV32I integer rules, x0 stays zero
    task automatic model_retire(input logic [31:0] instr, output logic we,
                                output logic [4:0] rd, output logic [31:0] value);
        logic [6:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        op = instr[6:0];
        rd = instr[11:7];
        a  = model_regs[instr[19:15]];
        b  = (op == 7'h33) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        sh = b[4:0];
        case (instr[14:12])
            3'd0: value = (op == 7'h33 && instr[30]) ? a - b : a + b;
            3'd1: value = a << sh;
            3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: value = (a < b) ? 32'd1 : 32'd0;
            3'd4: value = a ^ b;
            3'd5: begin
                if (instr[30]) value = $signed(a) >>> sh;
                else value = a >> sh;
            end
            3'd6: value = a | b;
            default: value = a & b;
        endcase
        if (op == 7'h37) value = {instr[31:12], 12'h000};
        we = (op == 7'h33 || op == 7'h13 || op == 7'h37) && rd != 5'd0;
        if (we) model_regs[rd] = value;
    endtask

    // ################################################
    // Reset and program runner
    // ################################################

    // Core sees rstn low for 5 edges
    task automatic apply_reset();
        @(posedge clk);
        rstn <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            assert (!retire_valid && !halt && !imem_req)
                else report_error("retire_valid, halt or imem_req high during reset");
        end
        @(posedge clk);
        rstn <= 1'b1;
        // First cycle after the core sees rstn high
        @(posedge clk);
        @(negedge clk);
        assert (imem_req && imem_addr == 32'h0)
            else report_error("no request to address 0 right after reset");
    endtask

    task automatic run_program(input string name, input int n_retire, input bit watch_halt);
        int          start_err;
        int          retired;
        logic [31:0] exp_pc;
        logic [31:0] instr;
        logic [31:0] value;
        logic [4:0]  rd;
        logic        we;
        logic        stop;
        start_err = errors + addr_errors;
        for (int i = 0; i < 32; i++) model_regs[5'(i)] = '0;
        apply_reset();
        exp_pc  = 32'h0;
        retired = 0;
        stop    = 1'b0;
        while (!stop) begin
            @(negedge clk);
            if (retire_valid) begin
                instr = imem[exp_pc[7:2]];
                model_retire(instr, we, rd, value);
                assert (retire_pc == exp_pc) else report_mismatch("retire_pc", retire_pc, exp_pc);
                assert (retire_we == we) else report_mismatch("retire_we", 32'(retire_we), 32'(we));
                assert (retire_rd == rd) else report_mismatch("retire_rd", 32'(retire_rd), 32'(rd));
                if (we) begin
                    assert (retire_value == value)
                        else report_mismatch("retire_value", retire_value, value);
                end
                exp_pc = exp_pc + 32'd4;
                retired++;
                // A halt from the core ends the program as well
                stop = halt || instr == ecall_instr || instr == ebreak_instr;
            end
        end
        assert (retired == n_retire)
            else report_error($sformatf("%0d instructions retired, %0d expected", retired, n_retire));
        assert (halt) else report_error("halt low after ECALL or EBREAK retired");
        if (watch_halt) begin
            repeat (30) begin
                @(negedge clk);
                assert (!retire_valid) else report_error("retire_valid pulsed after halt");
                assert (halt) else report_error("halt dropped before reset");
            end
            assert (!imem_req) else report_error("imem_req still high with buffer full after halt");
        end
        if (errors + addr_errors == start_err) begin
            n_pass++;
            $display("%s: pass", name);
        end else begin
            n_fail++;
            $display("%s: FAIL", name);
        end
    endtask

    // ################################################
    // Directed tests
    // ################################################

    task automatic test_reset();
        clear_program();
        emit(enc_i(5, 0, 0, 1));
        emit(ecall_instr);
        run_program("reset", 2, 1'b0);
    endtask

    task automatic test_itype();
        clear_program();
        emit(enc_i(-7, 0, 0, 1));
        emit(enc_i(100, 0, 0, 2));
        emit(enc_i(-5, 1, 2, 3));
        emit(enc_i(-5, 2, 2, 4));
        emit(enc_i(5, 1, 3, 5));
        emit(enc_i(-1, 2, 3, 6));
        emit(enc_i(240, 1, 4, 7));
        emit(enc_i(-256, 2, 6, 8));
        emit(enc_i(2047, 1, 7, 9));
        emit(enc_i(4, 1, 1, 10));
        emit(enc_i(3, 1, 5, 11));
        // SRAI carries funct7 bit 5 in the immediate
        emit(enc_i(1024 + 2, 1, 5, 12));
        emit(enc_i(1024 + 31, 2, 5, 13));
        emit(ecall_instr);
        run_program("i-type alu", 14, 1'b0);
    endtask

    // Each op reads the previous result
    task automatic test_rtype();
        clear_program();
        emit(enc_i(-20, 0, 0, 1));
        emit(enc_i(3, 0, 0, 2));
        emit(enc_r(0, 2, 1, 0, 3));
        emit(enc_r(32, 2, 3, 0, 4));
        emit(enc_r(0, 2, 4, 1, 5));
        emit(enc_r(0, 2, 5, 2, 6));
        emit(enc_r(0, 6, 5, 3, 7));
        emit(enc_r(0, 1, 7, 4, 8));
        emit(enc_r(32, 2, 8, 5, 9));
        emit(enc_r(0, 2, 9, 5, 10));
        emit(enc_r(0, 1, 10, 6, 11));
        emit(enc_r(0, 2, 11, 7, 12));
        emit(ebreak_instr);
        run_program("r-type chain", 13, 1'b0);
    endtask

    task automatic test_lui_x0();
        clear_program();
        emit(enc_lui(20'habcde, 1));
        emit(enc_lui(20'h12345, 0));
        emit(enc_i(7, 0, 0, 0));
        emit(enc_r(0, 0, 0, 0, 2));
        emit(enc_i(12'h123, 1, 6, 3));
        emit(enc_i(5, 0, 0, 4));
        emit(ecall_instr);
        run_program("lui and x0", 7, 1'b0);
    endtask

    task automatic test_order();
        clear_program();
        emit(enc_i(1, 0, 0, 1));
        for (int i = 1; i < 19; i++) begin
            emit(enc_i(i, ((i + 6) % 7) + 1, 0, (i % 7) + 1));
        end
        emit(ecall_instr);
        run_program("retire order", 20, 1'b0);
    endtask

    // Words after EBREAK must never retire
    task automatic test_halt();
        clear_program();
        emit(enc_i(1, 0, 0, 1));
        emit(enc_i(2, 1, 0, 2));
        emit(ebreak_instr);
        emit(enc_i(9, 0, 0, 3));
        emit(enc_i(9, 0, 0, 4));
        run_program("halt", 3, 1'b1);
    endtask

    initial begin
        void'($urandom(32'he3de9ff8));
        test_reset();
        test_itype();
        test_rtype();
        test_lui_x0();
        test_order();
        test_halt();
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors + addr_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: z_core_consts.svh
/*
 * Z-core constants
 * Widths, reset PC, PC step and fetch buffer depth shared by
 * the fetch, buffer and execute blocks of the integer core
 */

`ifndef Z_CORE_CONSTS_SVH
`define Z_CORE_CONSTS_SVH

// ################################################
// Datapath widths
// ################################################

// Data and address width, one word
`define Z_XLEN 32

// Register index width, 32 architectural registers
`define Z_REG_ADDR_W 5

// ################################################
// Program counter
// ################################################

// First fetch address after reset
`define Z_PC_RESET 32'h0000_0000

// Byte distance between sequential instructions
`define Z_PC_STEP 32'd4

// Default number of fetch buffer entries
`define Z_FETCH_BUF_DEPTH 2

`endif

// File: z_core_pkg.sv
/*
 * Z-core type package
 * Data word, register index, major opcodes, ALU operations
 * and the fetch state encoding
 */

`include "z_core_consts.svh"

package z_core_pkg;

    // One data or address word
    typedef logic [`Z_XLEN-1:0] word_t;

    // Register file index
    typedef logic [`Z_REG_ADDR_W-1:0] reg_addr_t;

    // Major opcode field, instr[6:0]
    // Only the in-scope classes are named
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_system = 7'b1110011
    } opcode_e;

    // Integer ALU operations
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // Fetch FSM states
    typedef enum logic {
        fs_idle,
        fs_wait
    } fetch_state_e;

endpackage

// File: z_core_top.sv
/*
 * Z-core top level
 * Fetch unit, fetch buffer and execute unit of the in-order
 * RV32I integer core, with instruction and retire ports
 */

`include "z_core_consts.svh"

module z_core_top (
    input  logic                  clk,
    input  logic                  rstn,
    // Instruction port
    output logic                  imem_req,
    output z_core_pkg::word_t     imem_addr,
    input  logic                  imem_ready,
    input  z_core_pkg::word_t     imem_rdata,
    // Retire port
    output logic                  retire_valid,
    output z_core_pkg::word_t     retire_pc,
    output z_core_pkg::reg_addr_t retire_rd,
    output logic                  retire_we,
    output z_core_pkg::word_t     retire_value,
    output logic                  halt
);

    // Fetch to buffer
    logic              push;
    z_core_pkg::word_t push_pc;
    z_core_pkg::word_t push_instr;
    logic              full;

    // Buffer to execute
    logic              empty;
    logic              pop;
    z_core_pkg::word_t head_pc;
    z_core_pkg::word_t head_instr;

    z_fetch_unit u_fetch (
        .clk(clk), .rstn(rstn),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata), .full(full),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .push(push), .push_pc(push_pc), .push_instr(push_instr)
    );

    z_fetch_buffer #(.DEPTH(`Z_FETCH_BUF_DEPTH)) u_buffer (
        .clk(clk), .rstn(rstn),
        .push(push), .push_pc(push_pc), .push_instr(push_instr), .pop(pop),
        .full(full), .empty(empty), .head_pc(head_pc), .head_instr(head_instr)
    );

    z_exec_unit u_exec (
        .clk(clk), .rstn(rstn),
        .empty(empty), .head_pc(head_pc), .head_instr(head_instr), .pop(pop),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value), .halt(halt)
    );

endmodule

// File: z_exec_unit.sv
/*
 * Execute unit
 * Decodes the buffer head, reads the register file, runs the ALU,
 * writes back and reports each retired instruction, halts on ECALL/EBREAK
 */

`include "z_core_consts.svh"

module z_exec_unit (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  empty,
    input  z_core_pkg::word_t     head_pc,
    input  z_core_pkg::word_t     head_instr,
    output logic                  pop,
    output logic                  retire_valid,
    output z_core_pkg::word_t     retire_pc,
    output z_core_pkg::reg_addr_t retire_rd,
    output logic                  retire_we,
    output z_core_pkg::word_t     retire_value,
    output logic                  halt
);

    // Register file, x0 never written
    z_core_pkg::word_t rf [2**`Z_REG_ADDR_W];

    z_core_pkg::opcode_e   opcode;
    z_core_pkg::alu_op_e   alu_op;
    z_core_pkg::reg_addr_t rs1;
    z_core_pkg::reg_addr_t rs2;
    z_core_pkg::reg_addr_t rd;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    z_core_pkg::word_t     imm_i;
    z_core_pkg::word_t     rs1_val;
    z_core_pkg::word_t     rs2_val;
    z_core_pkg::word_t     op_b;
    z_core_pkg::word_t     alu_res;
    z_core_pkg::word_t     result;
    logic                  writes_rd;
    logic                  is_halt;

    // ################################################
    // Decode
    // ################################################

    // Out-of-range opcodes fall to the default branches below
    assign opcode    = z_core_pkg::opcode_e'(head_instr[6:0]);
    assign rd        = head_instr[11:7];
    assign funct3    = head_instr[14:12];
    assign rs1       = head_instr[19:15];
    assign rs2       = head_instr[24:20];
    assign funct7_b5 = head_instr[30];
    assign imm_i     = {{(`Z_XLEN-12){head_instr[31]}}, head_instr[31:20]};

    // ALU op from funct3, funct7 bit 5 picks SUB and SRA
    always_comb begin
        case (funct3)
            3'd0: begin
                // No SUBI, bit 30 is immediate data there
                if (opcode == z_core_pkg::op_reg && funct7_b5) begin
                    alu_op = z_core_pkg::alu_sub;
                end else begin
                    alu_op = z_core_pkg::alu_add;
                end
            end
            3'd1:    alu_op = z_core_pkg::alu_sll;
            3'd2:    alu_op = z_core_pkg::alu_slt;
            3'd3:    alu_op = z_core_pkg::alu_sltu;
            3'd4:    alu_op = z_core_pkg::alu_xor;
            3'd5:    alu_op = funct7_b5 ? z_core_pkg::alu_sra : z_core_pkg::alu_srl;
            3'd6:    alu_op = z_core_pkg::alu_or;
            default: alu_op = z_core_pkg::alu_and;
        endcase
    end

    // ################################################
    // Operands and ALU
    // ################################################

    assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

    // Second operand: register or I-immediate
    // Shifts use only its low 5 bits, the shift amount field
    always_comb begin
        if (opcode == z_core_pkg::op_reg) begin
            op_b = rs2_val;
        end else begin
            op_b = imm_i;
        end
    end

    always_comb begin
        case (alu_op)
            z_core_pkg::alu_add:  alu_res = rs1_val + op_b;
            z_core_pkg::alu_sub:  alu_res = rs1_val - op_b;
            z_core_pkg::alu_sll:  alu_res = rs1_val << op_b[4:0];
            z_core_pkg::alu_slt:
                alu_res = {{(`Z_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            z_core_pkg::alu_sltu: alu_res = {{(`Z_XLEN-1){1'b0}}, rs1_val < op_b};
            z_core_pkg::alu_xor:  alu_res = rs1_val ^ op_b;
            z_core_pkg::alu_srl:  alu_res = rs1_val >> op_b[4:0];
            z_core_pkg::alu_sra:  alu_res = $signed(rs1_val) >>> op_b[4:0];
            z_core_pkg::alu_or:   alu_res = rs1_val | op_b;
            default:              alu_res = rs1_val & op_b;
        endcase
    end

    // LUI bypasses the ALU
    assign result = (opcode == z_core_pkg::op_lui) ? {head_instr[31:12], 12'b0} : alu_res;

    // Only ALU and LUI classes write, never x0
    assign writes_rd = (opcode == z_core_pkg::op_reg || opcode == z_core_pkg::op_imm ||
                        opcode == z_core_pkg::op_lui) && (rd != '0);

    // ECALL is imm 0, EBREAK imm 1
    assign is_halt = (opcode == z_core_pkg::op_system) && (funct3 == 3'd0) &&
                     (head_instr[31:21] == '0) && (head_instr[19:7] == '0);

    // Take the head whenever one is waiting
    assign pop = !empty && !halt;

    // ################################################
    // Writeback and retire
    // ################################################

    always_ff @(posedge clk) begin
        if (pop && writes_rd) begin
            rf[rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
            halt         <= 1'b0;
        end else begin
            retire_valid <= pop;
            retire_we    <= pop && writes_rd;
            // Sticky until the next reset
            if (pop && is_halt) halt <= 1'b1;
        end
    end

    // Retire payload, qualified by retire_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc    <= head_pc;
            retire_rd    <= rd;
            retire_value <= result;
        end
    end

endmodule

// File: z_fetch_buffer.sv
/*
 * Fetch buffer
 * Circular FIFO of instruction and PC pairs between fetch and
 * execute, with an occupancy count for full and empty
 */

`include "z_core_consts.svh"

module z_fetch_buffer #(
    parameter int DEPTH = `Z_FETCH_BUF_DEPTH
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              push,
    input  z_core_pkg::word_t push_pc,
    input  z_core_pkg::word_t push_instr,
    input  logic              pop,
    output logic              full,
    output logic              empty,
    output z_core_pkg::word_t head_pc,
    output z_core_pkg::word_t head_instr
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    z_core_pkg::word_t mem_pc    [DEPTH];
    z_core_pkg::word_t mem_instr [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // ################################################
    // Pointers and occupancy
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (push) wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop)  rd_ptr <= rd_ptr + PTR_W'(1);
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem_pc[wr_ptr]    <= push_pc;
            mem_instr[wr_ptr] <= push_instr;
        end
    end

    assign full       = (count == CNT_W'(DEPTH));
    assign empty      = (count == '0);
    assign head_pc    = mem_pc[rd_ptr];
    assign head_instr = mem_instr[rd_ptr];

    // Fetch only starts a request with room, so a push always fits
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
        else $error("push while fetch buffer full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty)
        else $error("pop while fetch buffer empty");

endmodule

// File: z_fetch_unit.sv
/*
 * Fetch unit
 * Holds the PC and requests one instruction at a time over the
 * instruction port, pushing each word and its PC into the buffer
 */

`include "z_core_consts.svh"

module z_fetch_unit (
    input  logic              clk,
    input  logic              rstn,
    input  logic              imem_ready,
    input  z_core_pkg::word_t imem_rdata,
    input  logic              full,
    output logic              imem_req,
    output z_core_pkg::word_t imem_addr,
    output logic              push,
    output z_core_pkg::word_t push_pc,
    output z_core_pkg::word_t push_instr
);

    z_core_pkg::fetch_state_e state;
    z_core_pkg::word_t        pc;

    // ################################################
    // Request FSM and program counter
    // ################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= z_core_pkg::fs_idle;
            pc    <= `Z_PC_RESET;
        end else begin
            case (state)
                z_core_pkg::fs_idle: begin
                    // Start a request only with room in the buffer
                    if (!full) begin
                        state <= z_core_pkg::fs_wait;
                    end
                end
                z_core_pkg::fs_wait: begin
                    // Word taken on this edge, step to next instruction
                    if (imem_ready) begin
                        state <= z_core_pkg::fs_idle;
                        pc    <= pc + `Z_PC_STEP;
                    end
                end
                default: state <= z_core_pkg::fs_idle;
            endcase
        end
    end

    // Request level follows the wait state
    assign imem_req  = (state == z_core_pkg::fs_wait);
    assign imem_addr = pc;

    // Push in the same edge that samples ready
    // Buffer count is updated before the next idle decision
    assign push       = imem_req && imem_ready;
    assign push_pc    = pc;
    assign push_instr = imem_rdata;

    // Request and address held until memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (state == z_core_pkg::fs_wait && !imem_ready) |=> (imem_req && $stable(imem_addr)))
        else $error("imem_addr or imem_req changed while fs_wait was pending");

endmodule
